/* src/cpu_bus_pkg.sv */
// Shared types for the narrow-bus CPU handler
// Frame phases, strobes, bus request and instruction encodings
`default_nettype none

package cpu_bus_pkg;

  // Phase number inside one 9-cycle bus frame
  typedef logic [3:0] frame_phase_t;

  localparam frame_phase_t phase_last = 4'd8;  // Frame wraps after this phase

  // Operations of the accumulator CPU, anything else is a no-op
  typedef enum logic [3:0] {
    op_load  = 4'h1,
    op_store = 4'h2,
    op_add   = 4'h3,
    op_jump  = 4'h4,
    op_halt  = 4'hf
  } opcode_t;

  // Instruction word layout
  typedef struct packed {
    opcode_t     opcode;   // Upper nibble
    logic [27:0] operand;  // Word address of operand or jump target
  } instr_fields_t;

  // One read word, seen as an instruction on a fetch and as data otherwise
  typedef union packed {
    instr_fields_t instr;
    logic [31:0]   data;
  } bus_word_u;

  // Full-width access as the CPU sees it
  typedef struct packed {
    logic [31:0] addr;   // Word address
    logic [31:0] wdata;  // Zero on reads
    logic        write;  // High for a store frame
  } bus_req_t;

  // Per-phase control from the sequencer
  typedef struct packed {
    logic cpu_step;    // Phase 0
    logic load_out;    // Phase 0, serializer captures the request
    logic shift_out;   // Phases 1 to 3
    logic capture_in;  // Phases 5 to 8
  } phase_strobes_t;

endpackage

`default_nettype wire

/* src/bus_phase_ctrl.sv */
// Frame phase sequencer for the narrow bus
// Counts the nine phases and hands out the CPU step and per-phase strobes
`timescale 1ns/1ps
`default_nettype none

module bus_phase_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       halted,
  output cpu_bus_pkg::phase_strobes_t strobes,
  output logic                       frame_sync
);

  cpu_bus_pkg::frame_phase_t   phase;
  cpu_bus_pkg::frame_phase_t   phase_next;
  cpu_bus_pkg::phase_strobes_t strobes_q;
  cpu_bus_pkg::phase_strobes_t strobes_next;
  logic                        frame_sync_q;

  always_comb begin
    if (halted) begin
      phase_next = '0;  // Park at the start of a frame
    end else if (phase == cpu_bus_pkg::phase_last) begin
      phase_next = '0;
    end else begin
      phase_next = phase + 4'd1;
    end
  end

  // Strobes are registered, so they line up with the phase they belong to
  always_comb begin
    strobes_next = '0;
    case (phase_next)
      4'd0: begin
        strobes_next.cpu_step = 1'b1;
        strobes_next.load_out = 1'b1;
      end
      4'd1, 4'd2, 4'd3: strobes_next.shift_out = 1'b1;
      4'd5, 4'd6, 4'd7, 4'd8: strobes_next.capture_in = 1'b1;
      default: strobes_next = '0;  // Phase 4 shows the last address byte
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase        <= '0;
      strobes_q    <= '0;
      frame_sync_q <= 1'b0;
    end else begin
      phase        <= phase_next;
      strobes_q    <= strobes_next;
      frame_sync_q <= strobes.load_out;  // Lowest address byte shows next cycle
    end
  end

  // Halt takes effect in the same cycle the CPU reports it
  assign strobes    = halted ? '0 : strobes_q;
  assign frame_sync = frame_sync_q & ~halted;

endmodule

`default_nettype wire

/* src/bus_byte_out.sv */
// Address and write-data serializer
// Loads a full request once per frame and presents it one byte per phase
`timescale 1ns/1ps
`default_nettype none

module bus_byte_out (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_bus_pkg::phase_strobes_t strobes,
  input  cpu_bus_pkg::bus_req_t       req,
  output logic [7:0]                  addr_out,
  output logic [7:0]                  data_out,
  output logic [7:0]                  data_oe
);

  logic [31:0] addr_sr;  // Address bytes still to go out
  logic [31:0] data_sr;  // Write bytes still to go out
  logic [7:0]  oe_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_sr <= '0;  // Pins read zero until the first frame
      data_sr <= '0;
      oe_q    <= '0;
    end else if (strobes.load_out) begin
      addr_sr <= req.addr;
      data_sr <= req.wdata;
      oe_q    <= {8{req.write}};  // Held for the whole frame
    end else if (strobes.shift_out) begin
      addr_sr <= {8'h00, addr_sr[31:8]};
      data_sr <= {8'h00, data_sr[31:8]};
    end
  end

  // Byte 3 stays on the pins from phase 4 until the next load
  assign addr_out = addr_sr[7:0];
  assign data_out = data_sr[7:0];
  assign data_oe  = oe_q;

endmodule

`default_nettype wire

/* src/bus_byte_in.sv */
// Read-data assembler
// Collects the four read bytes of a frame, lowest first, into one word
`timescale 1ns/1ps
`default_nettype none

module bus_byte_in (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_bus_pkg::phase_strobes_t strobes,
  input  logic [7:0]                  data_in,
  output logic [31:0]                 rdata
);

  logic [31:0] word_sr;

  // New bytes enter at the top and move down, so byte 0 ends in bits 7:0
  always_ff @(posedge clk) begin
    if (reset) begin
      word_sr <= '0;
    end else if (strobes.capture_in) begin
      word_sr <= {data_in, word_sr[31:8]};
    end
  end

  assign rdata = word_sr;  // Complete during phase 0

endmodule

`default_nettype wire

/* src/acc_cpu.sv */
// 32-bit accumulator CPU with one bus access per step
// Steps once per frame on the word read in the frame before
`timescale 1ns/1ps
`default_nettype none

module acc_cpu #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  step,
  input  logic [31:0]           rdata,
  output cpu_bus_pkg::bus_req_t req,
  output logic                  halted
);

  logic [31:0]                pc;
  logic [31:0]                acc;
  logic                       data_frame;  // Last access was a data access
  logic                       started;
  logic                       halted_q;
  cpu_bus_pkg::instr_fields_t instr;       // Instruction behind a data access

  logic [31:0]                pc_next;
  logic [31:0]                acc_next;
  logic                       data_frame_next;
  logic                       halted_next;
  cpu_bus_pkg::instr_fields_t instr_next;
  cpu_bus_pkg::bus_word_u     word;
  logic [31:0]                operand_addr;

  assign word         = rdata;
  assign operand_addr = {4'h0, word.instr.operand};

  // Next state and the request that the serializer loads on this step
  always_comb begin
    req             = '0;
    pc_next         = pc;
    acc_next        = acc;
    data_frame_next = 1'b0;
    halted_next     = halted_q;
    instr_next      = instr;
    if (!started) begin
      req.addr = reset_pc;  // First step, rdata holds nothing yet
      pc_next  = reset_pc;
    end else if (data_frame) begin
      case (instr.opcode)
        cpu_bus_pkg::op_load: acc_next = word.data;
        cpu_bus_pkg::op_add:  acc_next = acc + word.data;  // Wraps at 32 bits
        default:              acc_next = acc;              // Store is already done
      endcase
      pc_next  = pc + 32'd1;
      req.addr = pc + 32'd1;
    end else begin
      instr_next = word.instr;
      case (word.instr.opcode)
        cpu_bus_pkg::op_load, cpu_bus_pkg::op_add: begin
          req.addr        = operand_addr;
          data_frame_next = 1'b1;
        end
        cpu_bus_pkg::op_store: begin
          req.addr        = operand_addr;
          req.wdata       = acc;
          req.write       = 1'b1;
          data_frame_next = 1'b1;
        end
        cpu_bus_pkg::op_jump: begin
          req.addr = operand_addr;
          pc_next  = operand_addr;
        end
        cpu_bus_pkg::op_halt: begin
          req.addr    = pc;  // Never reaches the pins as a frame
          halted_next = 1'b1;
        end
        default: begin
          req.addr = pc + 32'd1;  // No-op
          pc_next  = pc + 32'd1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      acc        <= '0;
      data_frame <= 1'b0;
      started    <= 1'b0;
      halted_q   <= 1'b0;
    end else if (step && !halted_q) begin
      pc         <= pc_next;
      acc        <= acc_next;
      data_frame <= data_frame_next;
      started    <= 1'b1;
      halted_q   <= halted_next;
    end
  end

  always_ff @(posedge clk) begin
    if (step && !halted_q) begin
      instr <= instr_next;
    end
  end

  assign halted = halted_q;

endmodule

`default_nettype wire

/* src/cpu_bus_top.sv */
// Top level of the narrow-bus CPU handler
// Carries the CPU's 32-bit bus over three 8-bit pin groups in 9-phase frames
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_top #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic       clk,
  input  logic       reset,
  output logic [7:0] addr_out,
  output logic [7:0] data_out,
  input  logic [7:0] data_in,
  output logic [7:0] data_oe,
  output logic       frame_sync,
  output logic       halted
);

  cpu_bus_pkg::phase_strobes_t strobes;
  cpu_bus_pkg::bus_req_t       req;
  logic [31:0]                 rdata;

  bus_phase_ctrl phase_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .halted     (halted),
    .strobes    (strobes),
    .frame_sync (frame_sync)
  );

  acc_cpu #(
    .reset_pc (reset_pc)
  ) cpu_i (
    .clk    (clk),
    .reset  (reset),
    .step   (strobes.cpu_step),
    .rdata  (rdata),
    .req    (req),
    .halted (halted)
  );

  bus_byte_out byte_out_i (
    .clk      (clk),
    .reset    (reset),
    .strobes  (strobes),
    .req      (req),
    .addr_out (addr_out),
    .data_out (data_out),
    .data_oe  (data_oe)
  );

  bus_byte_in byte_in_i (
    .clk     (clk),
    .reset   (reset),
    .strobes (strobes),
    .data_in (data_in),
    .rdata   (rdata)
  );

endmodule

`default_nettype wire

/* verification/cpu_bus_assertions.sv */
// Protocol assertions for the narrow-bus CPU handler
// Bound to cpu_bus_top from the testbench, watches strobes, frame_sync and data_oe
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_assertions (
  input logic                        clk,
  input logic                        reset,
  input cpu_bus_pkg::phase_strobes_t strobes,
  input logic                        frame_sync,
  input logic [7:0]                  data_oe,
  input logic                        halted
);

  // Lowest address byte is announced one cycle after the serializer loads
  property sync_after_load;
    @(posedge clk) disable iff (reset)
      frame_sync == ($past(strobes.load_out) && !halted);
  endproperty

  // Output enable only changes right after a load
  property oe_held_in_frame;
    @(posedge clk) disable iff (reset)
      !strobes.load_out |=> $stable(data_oe);
  endproperty

  property no_shift_during_capture;
    @(posedge clk) disable iff (reset)
      !(strobes.capture_in && strobes.shift_out);
  endproperty

  property quiet_when_halted;
    @(posedge clk) disable iff (reset)
      halted |-> (strobes == '0);
  endproperty

  a_sync_after_load: assert property (sync_after_load)
    else $error("frame_sync did not follow load_out by one cycle");
  a_oe_held_in_frame: assert property (oe_held_in_frame)
    else $error("data_oe changed in the middle of a frame");
  a_no_shift_during_capture: assert property (no_shift_during_capture)
    else $error("capture_in and shift_out were high together");
  a_quiet_when_halted: assert property (quiet_when_halted)
    else $error("a strobe was high while the CPU was halted");

endmodule

`default_nettype wire

/* verification/cpu_bus_tb.sv */
// Testbench for the narrow-bus CPU handler
// Models a word memory on the byte pins, runs a short program and checks every frame
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_tb;

  localparam logic [31:0] start_pc     = 32'h0000_0010;
  localparam int          quiet_cycles = 18;  // Two frames of silence after halt

  logic       clk;
  logic       reset;
  logic [7:0] addr_out;
  logic [7:0] data_out;
  logic [7:0] data_in;
  logic [7:0] data_oe;
  logic       frame_sync;
  logic       halted;

  logic [31:0] mem [0:255];  // Word memory on the low 8 address bits

  // Program image
  logic [31:0] prog_addr[$];
  logic [31:0] prog_word[$];

  // Expected frames, one row per bus access
  logic [31:0] exp_addr[$];
  logic        exp_write[$];
  logic [31:0] exp_wdata[$];

  // Frames as seen on the pins
  logic [31:0] obs_addr[$];
  logic [31:0] obs_wdata[$];
  logic [7:0]  obs_oe[$];
  logic        obs_oe_steady[$];
  int          frames_seen = 0;

  int errors = 0;
  int checks = 0;

  cpu_bus_top #(
    .reset_pc (start_pc)
  ) cpu_bus_i (
    .clk        (clk),
    .reset      (reset),
    .addr_out   (addr_out),
    .data_out   (data_out),
    .data_in    (data_in),
    .data_oe    (data_oe),
    .frame_sync (frame_sync),
    .halted     (halted)
  );

  bind cpu_bus_top cpu_bus_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .strobes    (strobes),
    .frame_sync (frame_sync),
    .data_oe    (data_oe),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50;
      clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  function automatic logic [31:0] make_instr(input cpu_bus_pkg::opcode_t op,
                                             input logic [27:0] operand);
    cpu_bus_pkg::bus_word_u word;
    word.instr.opcode  = op;
    word.instr.operand = operand;
    return word.data;
  endfunction

  task automatic add_instr(input logic [31:0] addr, input cpu_bus_pkg::opcode_t op,
                           input logic [27:0] operand);
    prog_addr.push_back(addr);
    prog_word.push_back(make_instr(op, operand));
  endtask

  task automatic expect_frame(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata);
    exp_addr.push_back(addr);
    exp_write.push_back(write);
    exp_wdata.push_back(wdata);
  endtask

  // Program and expected frames, data words taken from the random fill
  task automatic build_tables();
    logic [31:0] word_a;
    logic [31:0] word_b;
    logic [31:0] sum;
    word_a = mem[8'h80];
    word_b = mem[8'h81];
    sum    = word_a + word_b;  // Wraps at 32 bits
    add_instr(32'h10, cpu_bus_pkg::op_load,  28'h80);
    add_instr(32'h11, cpu_bus_pkg::op_store, 28'h90);
    add_instr(32'h12, cpu_bus_pkg::op_add,   28'h81);
    add_instr(32'h13, cpu_bus_pkg::op_store, 28'h91);
    add_instr(32'h14, cpu_bus_pkg::op_jump,  28'h20);
    add_instr(32'h20, cpu_bus_pkg::op_load,  28'h91);  // Reads back the stored sum
    add_instr(32'h21, cpu_bus_pkg::op_store, 28'h92);
    add_instr(32'h22, cpu_bus_pkg::op_halt,  28'h0);
    expect_frame(start_pc, 1'b0, 32'h0);
    expect_frame(32'h80, 1'b0, 32'h0);
    expect_frame(32'h11, 1'b0, 32'h0);
    expect_frame(32'h90, 1'b1, word_a);
    expect_frame(32'h12, 1'b0, 32'h0);
    expect_frame(32'h81, 1'b0, 32'h0);
    expect_frame(32'h13, 1'b0, 32'h0);
    expect_frame(32'h91, 1'b1, sum);
    expect_frame(32'h14, 1'b0, 32'h0);
    expect_frame(32'h20, 1'b0, 32'h0);  // Jump target
    expect_frame(32'h91, 1'b0, 32'h0);
    expect_frame(32'h21, 1'b0, 32'h0);
    expect_frame(32'h92, 1'b1, sum);
    expect_frame(32'h22, 1'b0, 32'h0);
  endtask

  task automatic check_idle_pins();
    check_value("addr_out", 32'h0, {24'h0, addr_out});
    check_value("data_out", 32'h0, {24'h0, data_out});
    check_value("data_oe", 32'h0, {24'h0, data_oe});
    check_value("frame_sync", 32'h0, {31'h0, frame_sync});
  endtask

  // Memory on the pins; phase_cnt is the frame phase that the edge ends
  initial begin : memory_model
    int          phase_cnt;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic [31:0] rd_word;
    logic [7:0]  cur_oe;
    logic        oe_steady;
    phase_cnt = 0;
    rd_word   = '0;
    data_in  <= 8'h00;
    forever begin
      @(posedge clk);
      if (frame_sync) begin
        phase_cnt = 1;
        cur_addr  = {addr_out, 24'h0};  // Bytes enter at the top
        cur_wdata = {data_out, 24'h0};
        cur_oe    = data_oe;
        oe_steady = 1'b1;
      end else if (phase_cnt != 0) begin
        phase_cnt++;
        if (phase_cnt <= 4) begin
          cur_addr  = {addr_out, cur_addr[31:8]};
          cur_wdata = {data_out, cur_wdata[31:8]};
          if (data_oe !== cur_oe) oe_steady = 1'b0;
        end
        case (phase_cnt)
          4: begin
            if (cur_oe == 8'hff) mem[cur_addr[7:0]] = cur_wdata;
            rd_word  = mem[cur_addr[7:0]];
            data_in <= rd_word[7:0];  // Sampled at the end of phase 5
            obs_addr.push_back(cur_addr);
            obs_wdata.push_back(cur_wdata);
            obs_oe.push_back(cur_oe);
            obs_oe_steady.push_back(oe_steady);
            frames_seen++;
          end
          5: data_in <= rd_word[15:8];
          6: data_in <= rd_word[23:16];
          7: begin
            data_in  <= rd_word[31:24];
            phase_cnt = 0;
          end
          default: ;
        endcase
      end
    end
  end

  initial begin : watchdog
    int limit_cycles;
    #1;
    limit_cycles = (exp_addr.size() + 4) * 9;
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main_sequence
    int quiet_syncs;
    reset <= 1'b1;
    void'($urandom(69367));
    for (int a = 0; a < 256; a++) mem[a[7:0]] = $urandom;
    build_tables();
    for (int k = 0; k < prog_addr.size(); k++) mem[prog_addr[k][7:0]] = prog_word[k];
    quiet_syncs = 0;

    @(posedge clk);
    @(negedge clk);
    check_idle_pins();
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle_pins();
    @(negedge clk);
    check_idle_pins();  // First cycle out of reset

    for (int i = 0; i < exp_addr.size(); i++) begin
      while (frames_seen <= i) @(negedge clk);
      check_value($sformatf("address frame %0d", i), exp_addr[i], obs_addr[i]);
      check_value($sformatf("data_oe frame %0d", i), {24'h0, {8{exp_write[i]}}},
                  {24'h0, obs_oe[i]});
      check_value($sformatf("data_oe steady frame %0d", i), 32'h1,
                  {31'h0, obs_oe_steady[i]});
      check_value($sformatf("write data frame %0d", i), exp_wdata[i], obs_wdata[i]);
    end

    while (halted !== 1'b1) @(negedge clk);
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (frame_sync) quiet_syncs++;
    end
    check_value("frame_sync pulses after halt", 32'h0, quiet_syncs);
    check_value("halted", 32'h1, {31'h0, halted});
    check_value("frame count", exp_addr.size(), frames_seen);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
src/cpu_bus_pkg.sv
src/bus_phase_ctrl.sv
src/bus_byte_out.sv
src/bus_byte_in.sv
src/acc_cpu.sv
src/cpu_bus_top.sv
verification/cpu_bus_assertions.sv
verification/cpu_bus_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpu_bus_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
